/* source/dmem_macros.svh */
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// core-side byte address width
`define DMEM_ADDR_W 32

// data width on both sides, one word
`define DMEM_DATA_W 32

// bytes per memory word
// byte offset width follows from this
`define DMEM_WORD_BYTES 4

`endif

/* source/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

    // access size as seen by the core
    // byte, half-word, word; the fourth code is unused
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } mem_size_e;

    // sequencer states
    // loads:  idle -> rd_req -> rd_wait [-> rd_req2 -> rd_wait2] -> merge -> ld_push
    // stores: idle -> [reads as above -> merge ->] wr_req [-> wr_req2]
    typedef enum logic [3:0] {
        // waiting for a start pulse
        idle     = 4'd0,
        // first aligned read beat offered
        rd_req   = 4'd1,
        // first read data outstanding
        rd_wait  = 4'd2,
        // second aligned read beat, address plus one word
        rd_req2  = 4'd3,
        rd_wait2 = 4'd4,
        // one cycle to register the load result
        merge    = 4'd5,
        // load answer pulse
        ld_push  = 4'd6,
        // first write beat
        wr_req   = 4'd7,
        // second write beat for a store crossing a word
        wr_req2  = 4'd8
    } seq_state_e;

endpackage

`default_nettype wire

/* source/dmem_bus_if.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

interface dmem_bus_if;
    import dmem_pkg::*;

    // latched request
    logic                                write;
    mem_size_e                           size;
    logic [`DMEM_ADDR_W-1:0]             addr;
    logic [`DMEM_DATA_W-1:0]             wdata;

    // derived from the latched request
    logic [`DMEM_ADDR_W-1:0]             aligned_addr;
    logic [$clog2(`DMEM_WORD_BYTES)-1:0] offset;
    logic                                needs_read;
    logic                                two_word;

    // handshake between the two blocks
    logic                                start;
    logic                                done;
    logic                                idle;

    modport decode (
        output write, size, addr, wdata,
        output aligned_addr, offset, needs_read, two_word,
        output start,
        input  done, idle
    );

    modport sequencer (
        input  write, aligned_addr, needs_read, two_word,
        input  start,
        output done, idle
    );

endinterface

`default_nettype wire

/* source/access_decode.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module access_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_wen,
    input  dmem_pkg::mem_size_e     req_size,
    input  logic [`DMEM_ADDR_W-1:0] req_addr,
    input  logic [`DMEM_DATA_W-1:0] req_wdata,
    dmem_bus_if.decode              bus
);
    import dmem_pkg::*;

    localparam int OFF_W = $clog2(`DMEM_WORD_BYTES);

    logic                    accept;
    // access in progress, from acceptance to done
    logic                    busy_q;
    // store decode and check cycle
    logic                    check_q;
    logic                    wen_q;
    mem_size_e               size_q;
    logic [`DMEM_ADDR_W-1:0] addr_q;
    logic [`DMEM_DATA_W-1:0] wdata_q;

    // also closed during the store check cycle, sequencer still idle there
    assign req_ready = bus.idle && !busy_q;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            check_q <= 1'b0;
        end else begin
            check_q <= accept && req_wen;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (bus.done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            wen_q   <= req_wen;
            size_q  <= req_size;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    assign bus.write = wen_q;
    assign bus.size  = size_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    assign bus.aligned_addr = {bus.addr[`DMEM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign bus.offset       = bus.addr[OFF_W-1:0];

    // half at the last byte, or any misaligned word, crosses into the next word
    always_comb begin
        case (bus.size)
            size_h:  bus.two_word = (bus.offset == OFF_W'(`DMEM_WORD_BYTES - 1));
            size_w:  bus.two_word = (bus.offset != '0);
            default: bus.two_word = 1'b0;
        endcase
    end

    // only an aligned full-word store skips the pre-read
    // a start outside the check cycle is a load, which always reads
    assign bus.needs_read = !(check_q && bus.size == size_w && bus.offset == '0);

    // loads start in the accept cycle, stores one cycle later
    assign bus.start = (accept && !req_wen) || check_q;

endmodule

`default_nettype wire

/* source/access_sequencer.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module access_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    dmem_bus_if.sequencer           bus,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic                    mem_req_wen,
    output logic [`DMEM_ADDR_W-1:0] mem_req_addr,
    output logic [`DMEM_DATA_W-1:0] mem_req_wdata,
    input  logic                    mem_resp_valid,
    input  logic [`DMEM_DATA_W-1:0] mem_resp_rdata,
    output logic [`DMEM_DATA_W-1:0] word0,
    output logic [`DMEM_DATA_W-1:0] word1,
    input  logic [`DMEM_DATA_W-1:0] st_word0,
    input  logic [`DMEM_DATA_W-1:0] st_word1,
    output logic                    resp_valid
);
    import dmem_pkg::*;

    seq_state_e              state;
    logic                    second;
    logic                    beat_done;
    logic [`DMEM_DATA_W-1:0] word0_q;
    logic [`DMEM_DATA_W-1:0] word1_q;

    // beat handshake on the memory side
    assign beat_done = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (bus.start) begin
                        state <= bus.needs_read ? rd_req : wr_req;
                    end
                end
                rd_req: begin
                    if (mem_req_ready) begin
                        state <= rd_wait;
                    end
                end
                rd_wait: begin
                    if (mem_resp_valid) begin
                        state <= bus.two_word ? rd_req2 : merge;
                    end
                end
                rd_req2: begin
                    if (mem_req_ready) begin
                        state <= rd_wait2;
                    end
                end
                rd_wait2: begin
                    if (mem_resp_valid) begin
                        state <= merge;
                    end
                end
                merge: begin
                    // old words are in place, store words settle here
                    state <= bus.write ? wr_req : ld_push;
                end
                ld_push: begin
                    state <= idle;
                end
                wr_req: begin
                    if (mem_req_ready) begin
                        state <= bus.two_word ? wr_req2 : idle;
                    end
                end
                wr_req2: begin
                    if (mem_req_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // captured read words
    // cleared at start, so a word not read reaches the merge as zero
    always_ff @(posedge clk) begin
        if (state == idle && bus.start) begin
            word0_q <= '0;
            word1_q <= '0;
        end else if (state == rd_wait && mem_resp_valid) begin
            word0_q <= mem_resp_rdata;
        end else if (state == rd_wait2 && mem_resp_valid) begin
            word1_q <= mem_resp_rdata;
        end
    end

    assign word0 = word0_q;
    assign word1 = word1_q;

    // beat fields depend on state and latched values only
    // so they stay stable while the memory stalls
    assign mem_req_valid = (state == rd_req) || (state == rd_req2) ||
                           (state == wr_req) || (state == wr_req2);
    assign mem_req_wen   = (state == wr_req) || (state == wr_req2);

    // second word at aligned plus one word, wraps at the top of memory
    assign second        = (state == rd_req2) || (state == wr_req2);
    assign mem_req_addr  = second ? bus.aligned_addr + `DMEM_ADDR_W'(`DMEM_WORD_BYTES)
                                  : bus.aligned_addr;
    assign mem_req_wdata = (state == wr_req2) ? st_word1 : st_word0;

    // one-cycle load answer, no ready on the core side
    assign resp_valid = (state == ld_push);

    assign bus.idle = (state == idle);

    // last cycle of the access, ld_push or the final write beat
    assign bus.done = (state == ld_push) ||
                      (state == wr_req && beat_done && !bus.two_word) ||
                      (state == wr_req2 && beat_done);

endmodule

`default_nettype wire

/* source/lane_merge.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module lane_merge (
    input  logic                                clk,
    input  logic [`DMEM_DATA_W-1:0]             word0,
    input  logic [`DMEM_DATA_W-1:0]             word1,
    input  logic [$clog2(`DMEM_WORD_BYTES)-1:0] offset,
    input  dmem_pkg::mem_size_e                 size,
    input  logic [`DMEM_DATA_W-1:0]             wdata,
    output logic [`DMEM_DATA_W-1:0]             result,
    output logic [`DMEM_DATA_W-1:0]             st_word0,
    output logic [`DMEM_DATA_W-1:0]             st_word1
);
    import dmem_pkg::*;

    localparam int DW = `DMEM_DATA_W;
    localparam int NB = `DMEM_WORD_BYTES;
    localparam int BW = DW / NB;

    // byte lanes covered by the access size, from lane 0
    logic [NB-1:0]   size_en;
    logic [DW-1:0]   size_mask;
    // same lanes moved to the offset over the word pair
    logic [2*NB-1:0] byte_en;
    logic [2*DW-1:0] bit_en;
    logic [2*DW-1:0] pair;
    logic [2*DW-1:0] ins;
    logic [2*DW-1:0] merged;
    logic [2*DW-1:0] shifted;

    always_comb begin
        case (size)
            size_b:  size_en = NB'(1);
            size_h:  size_en = NB'(3);
            default: size_en = '1;
        endcase
    end

    // little-endian: lowest address in the low lane
    assign pair    = {word1, word0};
    assign byte_en = {{NB{1'b0}}, size_en} << offset;

    always_comb begin
        for (int i = 0; i < 2 * NB; i++) begin
            bit_en[i*BW +: BW] = {BW{byte_en[i]}};
        end
        for (int i = 0; i < NB; i++) begin
            size_mask[i*BW +: BW] = {BW{size_en[i]}};
        end
    end

    // store data placed at the offset, old bytes kept outside the lanes
    // an aligned word store covers all of word0, so wdata goes through as is
    assign ins      = {{DW{1'b0}}, wdata} << (BW * offset);
    assign merged   = (pair & ~bit_en) | (ins & bit_en);
    assign st_word0 = merged[DW-1:0];
    assign st_word1 = merged[2*DW-1:DW];

    // load result, addressed byte moved to lane 0
    assign shifted = pair >> (BW * offset);

    // registered in the merge cycle, read out in ld_push
    // upper lanes zeroed for byte and half loads
    always_ff @(posedge clk) begin
        result <= shifted[DW-1:0] & size_mask;
    end

endmodule

`default_nettype wire

/* source/dmem_unaligned_top.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module dmem_unaligned_top (
    input  logic                    clk,
    input  logic                    rst,
    // core side
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_wen,
    input  dmem_pkg::mem_size_e     req_size,
    input  logic [`DMEM_ADDR_W-1:0] req_addr,
    input  logic [`DMEM_DATA_W-1:0] req_wdata,
    output logic                    resp_valid,
    output logic [`DMEM_DATA_W-1:0] resp_rdata,
    // memory side, word aligned
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic                    mem_req_wen,
    output logic [`DMEM_ADDR_W-1:0] mem_req_addr,
    output logic [`DMEM_DATA_W-1:0] mem_req_wdata,
    input  logic                    mem_resp_valid,
    input  logic [`DMEM_DATA_W-1:0] mem_resp_rdata
);

    // captured old words and the merged store words
    logic [`DMEM_DATA_W-1:0] word0;
    logic [`DMEM_DATA_W-1:0] word1;
    logic [`DMEM_DATA_W-1:0] st_word0;
    logic [`DMEM_DATA_W-1:0] st_word1;

    dmem_bus_if bus ();

    access_decode i_access_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .bus       (bus.decode)
    );

    access_sequencer i_access_sequencer (
        .clk            (clk),
        .rst            (rst),
        .bus            (bus.sequencer),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_wen    (mem_req_wen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .word0          (word0),
        .word1          (word1),
        .st_word0       (st_word0),
        .st_word1       (st_word1),
        .resp_valid     (resp_valid)
    );

    // byte lanes from the latched request fields
    lane_merge i_lane_merge (
        .clk      (clk),
        .word0    (word0),
        .word1    (word1),
        .offset   (bus.offset),
        .size     (bus.size),
        .wdata    (bus.wdata),
        .result   (resp_rdata),
        .st_word0 (st_word0),
        .st_word1 (st_word1)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    // 8 ns period
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released right after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* verification/tb_mem_model.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module tb_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_req_valid,
    output logic                    mem_req_ready,
    input  logic                    mem_req_wen,
    input  logic [`DMEM_ADDR_W-1:0] mem_req_addr,
    input  logic [`DMEM_DATA_W-1:0] mem_req_wdata,
    output logic                    mem_resp_valid,
    output logic [`DMEM_DATA_W-1:0] mem_resp_rdata
);
    // sparse word store, only written words are kept
    logic [`DMEM_DATA_W-1:0] words [logic [`DMEM_ADDR_W-1:0]];
    integer                  seed;
    logic [31:0]             rnd;
    // ready-low cycles left after a beat
    logic [1:0]              accept_cnt;
    // cycles left before read data returns
    logic [1:0]              resp_cnt;
    logic                    pending;
    logic [`DMEM_DATA_W-1:0] pend_data;

    initial seed = 32'hc6ea_e7b0;

    // content of a word never written, mixes all address bits
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_req_ready  <= 1'b0;
            mem_resp_valid <= 1'b0;
            mem_resp_rdata <= '0;
            accept_cnt     <= 2'd0;
            resp_cnt       <= 2'd0;
            pending        <= 1'b0;
            pend_data      <= '0;
        end else begin
            mem_resp_valid <= 1'b0;
            // single-cycle read response
            if (pending) begin
                if (resp_cnt == 2'd0) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_rdata <= pend_data;
                    pending        <= 1'b0;
                end else begin
                    resp_cnt <= resp_cnt - 2'd1;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                rnd = $random(seed);
                mem_req_ready <= 1'b0;
                accept_cnt    <= rnd[1:0];
                if (mem_req_wen) begin
                    words[mem_req_addr] = mem_req_wdata;
                end else begin
                    pending   <= 1'b1;
                    resp_cnt  <= rnd[3:2];
                    pend_data <= words.exists(mem_req_addr) ? words[mem_req_addr]
                                                            : fill_word(mem_req_addr);
                end
            end else if (!mem_req_ready) begin
                // back-pressure, 0 to 3 extra cycles
                if (accept_cnt == 2'd0) begin
                    mem_req_ready <= 1'b1;
                end else begin
                    accept_cnt <= accept_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_dmem_unaligned.sv */
`default_nettype none
`timescale 1ns/1ns
`include "dmem_macros.svh"

module tb_dmem_unaligned;
    import dmem_pkg::*;

    // slowest access has two reads and two writes under full memory stalls
    localparam int ACCESS_WORST = 40;
    // 13 loads, 24 narrow store/readback, 11 word store/readback, 200 random
    localparam int N_ACCESSES   = 248;
    localparam int CYCLE_LIMIT  = 8 + N_ACCESSES * ACCESS_WORST;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    logic                    req_ready;
    logic                    req_wen;
    mem_size_e               req_size;
    logic [`DMEM_ADDR_W-1:0] req_addr;
    logic [`DMEM_DATA_W-1:0] req_wdata;
    logic                    resp_valid;
    logic [`DMEM_DATA_W-1:0] resp_rdata;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic                    mem_req_wen;
    logic [`DMEM_ADDR_W-1:0] mem_req_addr;
    logic [`DMEM_DATA_W-1:0] mem_req_wdata;
    logic                    mem_resp_valid;
    logic [`DMEM_DATA_W-1:0] mem_resp_rdata;

    integer                  seed;
    int                      cycles = 0;
    logic [31:0]             rd_beats = '0;
    logic [31:0]             wr_beats = '0;
    // byte-wide little-endian shadow of memory
    logic [7:0]              shadow [logic [31:0]];

    // beat offered in the last cycle and not taken by the memory
    logic                    beat_stalled = 1'b0;
    logic                    stalled_wen;
    logic [`DMEM_ADDR_W-1:0] stalled_addr;
    logic [`DMEM_DATA_W-1:0] stalled_wdata;

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    tb_mem_model i_mem_model (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_wen    (mem_req_wen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    dmem_unaligned_top i_dmem_unaligned_top (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_wen        (req_wen),
        .req_size       (req_size),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_wen    (mem_req_wen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // memory beats seen on the bus
    always @(posedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready) begin
            if (mem_req_wen) begin
                wr_beats <= wr_beats + 32'd1;
            end else begin
                rd_beats <= rd_beats + 32'd1;
            end
        end
    end

    // memory-side beats are word aligned and held until the memory takes them
    always @(negedge clk) begin
        if (rst) begin
            beat_stalled = 1'b0;
        end else begin
            if (mem_req_valid) begin
                check_equal("mem_req_addr[1:0]", 32'(mem_req_addr[1:0]), 32'd0);
            end
            if (beat_stalled) begin
                check_equal("mem_req_valid", 32'(mem_req_valid), 32'd1);
                check_equal("mem_req_wen", 32'(mem_req_wen), 32'(stalled_wen));
                check_equal("mem_req_addr", mem_req_addr, stalled_addr);
                check_equal("mem_req_wdata", mem_req_wdata, stalled_wdata);
            end
            beat_stalled  = mem_req_valid && !mem_req_ready;
            stalled_wen   = mem_req_wen;
            stalled_addr  = mem_req_addr;
            stalled_wdata = mem_req_wdata;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // same rule as the memory model's unwritten words
    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        w = initial_word({a[31:2], 2'b00});
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic int size_bytes(input mem_size_e s);
        case (s)
            size_b:  return 1;
            size_h:  return 2;
            default: return 4;
        endcase
    endfunction

    // 0 byte, 1 half, anything else word
    function automatic mem_size_e size_from_index(input int k);
        case (k)
            0:       return size_b;
            1:       return size_h;
            default: return size_w;
        endcase
    endfunction

    // size bytes from addr upward and zero-extended
    // addresses wrap at 2^32
    function automatic logic [31:0] expected_load(input mem_size_e s, input logic [31:0] addr);
        logic [31:0] exp;
        exp = '0;
        for (int i = 0; i < size_bytes(s); i++) begin
            exp[8*i +: 8] = shadow_byte(addr + 32'(i));
        end
        return exp;
    endfunction

    // one access with ready low the whole time
    // a store ends when ready returns, a load pulses resp_valid once
    task automatic do_access(input logic wen, input mem_size_e size, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        while (!req_ready) @(negedge clk);
        req_valid = 1'b1;
        req_wen   = wen;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge clk);
        req_valid = 1'b0;
        check_equal("req_ready", 32'(req_ready), 32'd0);
        rdata = '0;
        if (wen) begin
            while (!req_ready) begin
                check_equal("resp_valid", 32'(resp_valid), 32'd0);
                @(negedge clk);
            end
        end else begin
            while (!resp_valid) begin
                check_equal("req_ready", 32'(req_ready), 32'd0);
                @(negedge clk);
            end
            check_equal("req_ready", 32'(req_ready), 32'd0);
            rdata = resp_rdata;
            @(negedge clk);
            check_equal("resp_valid", 32'(resp_valid), 32'd0);
        end
    endtask

    task automatic load_and_compare(input mem_size_e size, input logic [31:0] addr);
        logic [31:0] exp;
        logic [31:0] got;
        exp = expected_load(size, addr);
        do_access(1'b0, size, addr, 32'd0, got);
        check_equal("resp_rdata", got, exp);
    endtask

    task automatic store_and_track(input mem_size_e size, input logic [31:0] addr,
                                   input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        do_access(1'b1, size, addr, wdata, unused_rdata);
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[addr + 32'(i)] = wdata[8*i +: 8];
        end
    endtask

    task automatic reset_values();
        check_equal("req_ready", 32'(req_ready), 32'd1);
        check_equal("resp_valid", 32'(resp_valid), 32'd0);
        check_equal("mem_req_valid", 32'(mem_req_valid), 32'd0);
    endtask

    task automatic aligned_and_crossing_loads();
        for (int k = 0; k < 3; k++) begin
            for (int off = 0; off < 4; off++) begin
                load_and_compare(size_from_index(k), 32'h0000_1000 + 32'(off));
            end
        end
        // crosses the top of the address space into word 0
        load_and_compare(size_w, 32'hffff_fffe);
    endtask

    // fresh word pair per offset so neighbours still hold the fill
    task automatic narrow_stores_keep_neighbours();
        logic [31:0] base;
        for (int k = 0; k < 2; k++) begin
            for (int off = 0; off < 4; off++) begin
                base = 32'h0000_1100 + 32'(k) * 32'h100 + 32'(off) * 32'd8;
                store_and_track(size_from_index(k), base + 32'(off),
                                32'h8c4f_27e0 + 32'(off * 17 + k));
                load_and_compare(size_w, base);
                load_and_compare(size_w, base + 32'd4);
            end
        end
    endtask

    task automatic word_stores();
        logic [31:0] base;
        logic [31:0] rd_before;
        logic [31:0] wr_before;
        for (int off = 1; off < 4; off++) begin
            base = 32'h0000_1300 + 32'(off) * 32'd8;
            store_and_track(size_w, base + 32'(off), 32'h3b91_d6a0 ^ 32'(off));
            load_and_compare(size_w, base);
            load_and_compare(size_w, base + 32'd4);
        end
        // aligned word store takes one write beat and no pre-read
        rd_before = rd_beats;
        wr_before = wr_beats;
        store_and_track(size_w, 32'h0000_1340, 32'h6e21_f0c7);
        check_equal("read beats", rd_beats - rd_before, 32'd0);
        check_equal("write beats", wr_beats - wr_before, 32'd1);
        load_and_compare(size_w, 32'h0000_1340);
    endtask

    // mostly a small window and now and then the wrap region at the top
    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_size_e   size;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            wdata = $random(seed);
            if (r[6] && r[10]) begin
                addr = 32'hffff_fff0 | {28'd0, r[3:0]};
            end else begin
                addr = 32'h0000_2000 | {26'd0, r[5:0]};
            end
            size = size_from_index(32'(r[9:8]));
            if (r[7]) begin
                store_and_track(size, addr, wdata);
            end else begin
                load_and_compare(size, addr);
            end
        end
    endtask

    initial begin
        seed      = 32'hc6ea_e7b0;
        req_valid = 1'b0;
        req_wen   = 1'b0;
        req_size  = size_b;
        req_addr  = '0;
        req_wdata = '0;
        // first falling edge with reset released
        @(negedge clk);
        while (rst !== 1'b0) @(negedge clk);
        reset_values();
        aligned_and_crossing_loads();
        narrow_stores_keep_neighbours();
        word_stores();
        random_mix();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/dmem_pkg.sv
source/dmem_bus_if.sv
source/access_decode.sv
source/access_sequencer.sv
source/lane_merge.sv
source/dmem_unaligned_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_dmem_unaligned.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# exit status is the simulator's own
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_dmem_unaligned
OBJ_DIR=obj_dir
SIM_BIN="sim_${TOP}"

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ns \
    --top-module "${TOP}" --Mdir "${OBJ_DIR}" -o "${SIM_BIN}" \
    -f src.f
status=$?
if [ ${status} -ne 0 ]; then
    echo "build failed with status ${status}"
    exit ${status}
fi

"./${OBJ_DIR}/${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
    echo "simulation failed with status ${status}"
    exit ${status}
fi

echo "simulation passed"
exit 0
